/* compile.f */
+incdir+src
src/mha_num_pkg.sv
src/mha_beat_pkg.sv
src/mha_skew_line.sv
src/mha_pe.sv
src/mha_pe_array.sv
src/mha_partial_sum_combiner.sv
src/mha_proj_top.sv
testbench/mha_proj_checker.sv
testbench/tb_mha_proj.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_mha_proj \
		-f compile.f -Mdir obj_dir -o Vtb_mha_proj
	./obj_dir/Vtb_mha_proj | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

/* testbench/tb_mha_proj.sv */
`timescale 1ns/100ps
`include "mha_macros.svh"

module tb_mha_proj;

    import mha_num_pkg::*;
    import mha_beat_pkg::*;

    localparam int PERIOD    = 8;
    localparam int ROWS      = 8 + 200 + 4 + 4 + 20;
    localparam int NUM_LOADS = 6;
    // Each load costs drain, window and settle, about 30 cycles
    localparam int WD_LIMIT  = (ROWS + NUM_LOADS * 30 + 50) * PERIOD;

    logic    I_CLK;
    logic    I_ASYN_RSTN;
    x_beat_t x_beat;
    w_beat_t w_beat;
    y_beat_t y_beat;

    q_t     w_mat [`MHA_K_FULL][`MHA_N];
    q_row_t exp_q [$];
    int     strobe_q [$];
    int     cyc;
    int     err_data;
    int     err_time;
    bit     run_done;

    mha_proj_top dut (
        .I_CLK       (I_CLK),
        .I_ASYN_RSTN (I_ASYN_RSTN),
        .i_x_beat    (x_beat),
        .i_w_beat    (w_beat),
        .o_y_beat    (y_beat)
    );

    always #(PERIOD / 2) I_CLK = ~I_CLK;

    ////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////

    // Per term: sign and bits 27..13, plus bit 12, all sums wrap at 16 bits
    function automatic q_row_t mha_ref_row(input q_t w [`MHA_K_FULL][`MHA_N],
                                           input q_t x [`MHA_K_FULL]);
        q_row_t y;
        prod_t  p;
        q_t     t;
        for (int c = 0; c < `MHA_N; c++) begin
            y[c] = '0;
            for (int k = 0; k < `MHA_K_FULL; k++) begin
                p    = prod_t'(x[k]) * prod_t'(w[k][c]);
                t    = {p[31], p[27:13]} + {15'd0, p[12]};
                y[c] = y[c] + t;
            end
        end
        return y;
    endfunction

    ////////////////////////////////////////////////////////////////////////
    // Stimulus tasks
    ////////////////////////////////////////////////////////////////////////

    task automatic rand_row(output q_t x [`MHA_K_FULL]);
        for (int k = 0; k < `MHA_K_FULL; k++) begin
            x[k] = q_t'($urandom);
        end
    endtask

    task automatic rand_weights();
        for (int k = 0; k < `MHA_K_FULL; k++) begin
            for (int c = 0; c < `MHA_N; c++) begin
                w_mat[k][c] = q_t'($urandom);
            end
        end
    endtask

    // Drain the pipe, then shift rows in last first
    task automatic load_weights();
        repeat (10) @(negedge I_CLK);
        for (int i = 0; i < `MHA_K_HALF; i++) begin
            @(negedge I_CLK);
            w_beat.load = 1'b1;
            for (int c = 0; c < `MHA_N; c++) begin
                w_beat.row_lo[c] = w_mat[`MHA_K_HALF-1-i][c];
                w_beat.row_hi[c] = w_mat[`MHA_K_FULL-1-i][c];
            end
        end
        @(negedge I_CLK);
        w_beat <= '0;
        // Let the weights settle down the columns
        repeat (8) @(negedge I_CLK);
    endtask

    task automatic send_row(input q_t x [`MHA_K_FULL], input q_row_t exp_row);
        @(negedge I_CLK);
        x_beat.valid = 1'b1;
        for (int k = 0; k < `MHA_K_HALF; k++) begin
            x_beat.x_lo[k] = x[k];
            x_beat.x_hi[k] = x[`MHA_K_HALF+k];
        end
        exp_q.push_back(exp_row);
    endtask

    task automatic end_burst();
        @(negedge I_CLK);
        x_beat = '0;
    endtask

    task automatic rand_burst(input int n);
        q_t x [`MHA_K_FULL];
        for (int i = 0; i < n; i++) begin
            rand_row(x);
            send_row(x, mha_ref_row(w_mat, x));
        end
        end_burst();
    endtask

    ////////////////////////////////////////////////////////////////////////
    // Checking processes
    ////////////////////////////////////////////////////////////////////////

    // Input strobes as the DUT samples them
    always @(posedge I_CLK) begin
        cyc <= cyc + 1;
        if (I_ASYN_RSTN && x_beat.valid) begin
            strobe_q.push_back(cyc);
        end
    end

    // Outputs are settled on the falling edge
    always @(negedge I_CLK) begin
        q_row_t exp_row;
        int     t0;
        if (I_ASYN_RSTN && y_beat.valid) begin
            assert (exp_q.size() > 0 && strobe_q.size() > 0) else begin
                $display("ERROR: result arrived with no row outstanding");
                err_time++;
            end
            if (exp_q.size() > 0 && strobe_q.size() > 0) begin
                exp_row = exp_q.pop_front();
                t0      = strobe_q.pop_front();
                assert (cyc - t0 == 8) else begin
                    $display("ERROR: result came %0d cycles after its strobe, not 8",
                             cyc - t0);
                    err_time++;
                end
                assert (y_beat.y == exp_row) else begin
                    $display("mismatch o_y_beat.y got %h expected %h", y_beat.y, exp_row);
                    err_data++;
                end
            end
        end
    end

    initial begin
        #(WD_LIMIT);
        run_done = 1'b1;
        $display("ERROR: watchdog expired before all results came back");
        $display("Test failed");
        $finish;
    end

    // Run stopped by a failed assertion
    final begin
        if (!run_done) begin
            $display("Test failed");
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////

    initial begin
        q_t     x [`MHA_K_FULL];
        q_row_t exp_row;
        void'($urandom(32'h1138_6e52));
        I_CLK = 1'b0;
        I_ASYN_RSTN = 1'b0;
        x_beat = '0;
        w_beat = '0;
        cyc = 0;
        err_data = 0;
        err_time = 0;
        run_done = 1'b0;
        repeat (10) @(posedge I_CLK);
        @(negedge I_CLK);
        I_ASYN_RSTN = 1'b1;

        // Quiet output after reset
        repeat (5) begin
            @(negedge I_CLK);
            assert (!y_beat.valid && y_beat.y == '0) else begin
                $display("mismatch o_y_beat got %h expected 0", y_beat);
                err_data++;
            end
        end

        // Identity in the top four rows, expect x[0..3] back
        for (int k = 0; k < `MHA_K_FULL; k++) begin
            for (int c = 0; c < `MHA_N; c++) begin
                w_mat[k][c] = (k == c) ? 16'sh2000 : 16'sh0000;
            end
        end
        load_weights();
        for (int i = 0; i < 8; i++) begin
            rand_row(x);
            for (int c = 0; c < `MHA_N; c++) begin
                exp_row[c] = x[c];
            end
            send_row(x, exp_row);
        end
        end_burst();

        // Random weights, 200 rows back to back
        rand_weights();
        load_weights();
        rand_burst(200);

        // Rounding with half an LSB, positive and negative
        for (int k = 0; k < `MHA_K_FULL; k++) begin
            for (int c = 0; c < `MHA_N; c++) begin
                w_mat[k][c] = '0;
            end
        end
        w_mat[0][0] = 16'sh1000;
        w_mat[0][1] = 16'shF000;
        w_mat[1][2] = 16'sh1000;
        w_mat[5][3] = 16'shF000;
        load_weights();
        for (int i = 0; i < 4; i++) begin
            for (int k = 0; k < `MHA_K_FULL; k++) begin
                x[k] = '0;
            end
            x[0] = (i % 2 == 0) ? q_t'(i + 1) : -q_t'(i + 1);
            x[1] = (i < 2) ? 16'sh0001 : 16'shFFFF;
            x[5] = q_t'(3 - 2 * i);
            send_row(x, mha_ref_row(w_mat, x));
        end
        end_burst();

        // Large same-sign terms overflow the 16-bit sum
        for (int k = 0; k < `MHA_K_FULL; k++) begin
            for (int c = 0; c < `MHA_N; c++) begin
                w_mat[k][c] = (c % 2 == 0) ? 16'sh7FFF : 16'sh8000;
            end
        end
        load_weights();
        for (int i = 0; i < 4; i++) begin
            for (int k = 0; k < `MHA_K_FULL; k++) begin
                x[k] = (i < 2) ? 16'sh7FFF : 16'sh8000;
            end
            x[0] = (i % 2 == 0) ? x[0] : 16'sh6000;
            send_row(x, mha_ref_row(w_mat, x));
        end
        end_burst();

        // Two bursts around a reload
        rand_weights();
        load_weights();
        rand_burst(10);
        rand_weights();
        load_weights();
        rand_burst(10);

        while (exp_q.size() > 0) begin
            @(negedge I_CLK);
        end
        repeat (4) @(negedge I_CLK);

        run_done = 1'b1;
        $display("errors: data %0d, timing %0d", err_data, err_time);
        if (err_data == 0 && err_time == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* testbench/mha_proj_checker.sv */
`timescale 1ns/100ps
`include "mha_macros.svh"

module mha_proj_checker (
    input logic                  I_CLK,
    input logic                  I_ASYN_RSTN,
    input mha_beat_pkg::x_beat_t i_x_beat,
    input mha_beat_pkg::w_beat_t i_w_beat,
    input mha_beat_pkg::y_beat_t o_y_beat
);

    import mha_beat_pkg::*;

    // Output strobe quiet while in reset
    a_valid_in_reset: assert property (@(posedge I_CLK)
        !I_ASYN_RSTN |-> !o_y_beat.valid)
        else $error("output valid high during reset");

    // Fixed latency of 8 cycles, input to output
    a_latency: assert property (@(posedge I_CLK) disable iff (!I_ASYN_RSTN)
        o_y_beat.valid == $past(i_x_beat.valid, 8))
        else $error("output valid not aligned with input valid 8 cycles back");

    // Streaming and loading never overlap
    a_no_x_in_load: assert property (@(posedge I_CLK) disable iff (!I_ASYN_RSTN)
        i_w_beat.load |-> !i_x_beat.valid)
        else $error("x strobe inside a weight load window");

    // Load window is one row per PE row
    a_load_len: assert property (@(posedge I_CLK) disable iff (!I_ASYN_RSTN)
        $rose(i_w_beat.load) |-> i_w_beat.load [*`MHA_K_HALF] ##1 !i_w_beat.load)
        else $error("weight load level of wrong length");

endmodule

bind mha_proj_top mha_proj_checker u_chk (
    .I_CLK       (I_CLK),
    .I_ASYN_RSTN (I_ASYN_RSTN),
    .i_x_beat    (i_x_beat),
    .i_w_beat    (i_w_beat),
    .o_y_beat    (o_y_beat)
);

/* src/mha_proj_top.sv */
`timescale 1ns/100ps

module mha_proj_top (
    input  logic                  I_CLK,
    input  logic                  I_ASYN_RSTN,
    input  mha_beat_pkg::x_beat_t i_x_beat,
    input  mha_beat_pkg::w_beat_t i_w_beat,
    output mha_beat_pkg::y_beat_t o_y_beat
);

    import mha_num_pkg::*;

    // Aligned column sums of each half
    q_row_t sum_lo;
    q_row_t sum_hi;

    // W rows 0..3 against x[0..3]
    mha_pe_array u_arr_lo (
        .I_CLK       (I_CLK),
        .I_ASYN_RSTN (I_ASYN_RSTN),
        .i_x         (i_x_beat.x_lo),
        .i_w_row     (i_w_beat.row_lo),
        .i_w_load    (i_w_beat.load),
        .o_col_sum   (sum_lo)
    );

    // W rows 4..7 against x[4..7]
    mha_pe_array u_arr_hi (
        .I_CLK       (I_CLK),
        .I_ASYN_RSTN (I_ASYN_RSTN),
        .i_x         (i_x_beat.x_hi),
        .i_w_row     (i_w_beat.row_hi),
        .i_w_load    (i_w_beat.load),
        .o_col_sum   (sum_hi)
    );

    // Valid bypasses the arrays
    mha_partial_sum_combiner u_comb (
        .I_CLK       (I_CLK),
        .I_ASYN_RSTN (I_ASYN_RSTN),
        .i_valid     (i_x_beat.valid),
        .i_sum_lo    (sum_lo),
        .i_sum_hi    (sum_hi),
        .o_y_beat    (o_y_beat)
    );

endmodule

/* src/mha_partial_sum_combiner.sv */
`timescale 1ns/100ps
`include "mha_macros.svh"

module mha_partial_sum_combiner (
    input  logic                  I_CLK,
    input  logic                  I_ASYN_RSTN,
    input  logic                  i_valid,
    input  mha_num_pkg::q_row_t   i_sum_lo,
    input  mha_num_pkg::q_row_t   i_sum_hi,
    output mha_beat_pkg::y_beat_t o_y_beat
);

    import mha_num_pkg::*;

    logic   valid_dly;
    q_row_t sum_row;

    // Valid follows the array pipe, K+N-1 stages
    mha_skew_line #(
        .T     (logic),
        .DEPTH (`MHA_K_HALF + `MHA_N - 1)
    ) u_valid_dly (
        .I_CLK       (I_CLK),
        .I_ASYN_RSTN (I_ASYN_RSTN),
        .i_d         (i_valid),
        .o_d         (valid_dly)
    );

    // Per-column add, wraps at 16 bits
    always_comb begin
        for (int c = 0; c < `MHA_N; c++) begin
            sum_row[c] = i_sum_lo[c] + i_sum_hi[c];
        end
    end

    always_ff @(posedge I_CLK or negedge I_ASYN_RSTN) begin
        if (!I_ASYN_RSTN) begin
            o_y_beat <= '0;
        end else begin
            o_y_beat.valid <= valid_dly;
            // Row only moves on a real result
            if (valid_dly) begin
                o_y_beat.y <= sum_row;
            end
        end
    end

endmodule

/* src/mha_pe_array.sv */
`timescale 1ns/100ps
`include "mha_macros.svh"

module mha_pe_array (
    input  logic                     I_CLK,
    input  logic                     I_ASYN_RSTN,
    input  mha_num_pkg::q_half_vec_t i_x,
    input  mha_num_pkg::q_row_t      i_w_row,
    input  logic                     i_w_load,
    output mha_num_pkg::q_row_t      o_col_sum
);

    import mha_num_pkg::*;

    localparam int K = `MHA_K_HALF;
    localparam int N = `MHA_N;

    // Horizontal x links, column 0 is the skew output
    q_t   x_h  [K][N+1];
    // Vertical links, row 0 is the top edge
    q_t   d_v  [K+1][N];
    q_t   w_v  [K+1][N];
    logic ld_v [K+1][N];

    genvar r, c;

    ///////////////////////////////////////////////////////////////////////
    // Top edge and row skew
    ///////////////////////////////////////////////////////////////////////

    generate
        for (c = 0; c < N; c++) begin : g_top
            // Empty partial sums, weights and load enter from the top
            assign d_v[0][c]  = '0;
            assign w_v[0][c]  = i_w_row[c];
            assign ld_v[0][c] = i_w_load;
        end

        for (r = 0; r < K; r++) begin : g_row_skew
            // Row r waits r cycles for its partial sum
            mha_skew_line #(
                .T     (q_t),
                .DEPTH (r)
            ) u_skew (
                .I_CLK       (I_CLK),
                .I_ASYN_RSTN (I_ASYN_RSTN),
                .i_d         (i_x[r]),
                .o_d         (x_h[r][0])
            );
        end
    endgenerate

    ///////////////////////////////////////////////////////////////////////
    // PE grid
    ///////////////////////////////////////////////////////////////////////

    generate
        for (r = 0; r < K; r++) begin : g_pe_row
            for (c = 0; c < N; c++) begin : g_pe_col
                mha_pe u_pe (
                    .I_CLK       (I_CLK),
                    .I_ASYN_RSTN (I_ASYN_RSTN),
                    .i_x         (x_h[r][c]),
                    .i_w         (w_v[r][c]),
                    .i_d         (d_v[r][c]),
                    .i_load_up   (ld_v[r][c]),
                    .o_x         (x_h[r][c+1]),
                    .o_w         (w_v[r+1][c]),
                    .o_d         (d_v[r+1][c]),
                    .o_load_down (ld_v[r+1][c])
                );
            end
        end
    endgenerate

    ///////////////////////////////////////////////////////////////////////
    // Column deskew
    ///////////////////////////////////////////////////////////////////////

    generate
        for (c = 0; c < N; c++) begin : g_col_deskew
            // Left columns finish first, hold them back
            mha_skew_line #(
                .T     (q_t),
                .DEPTH (N - 1 - c)
            ) u_deskew (
                .I_CLK       (I_CLK),
                .I_ASYN_RSTN (I_ASYN_RSTN),
                .i_d         (d_v[K][c]),
                .o_d         (o_col_sum[c])
            );
        end
    endgenerate

endmodule

/* src/mha_pe.sv */
`timescale 1ns/100ps
`include "mha_macros.svh"

module mha_pe (
    input  logic            I_CLK,
    input  logic            I_ASYN_RSTN,
    input  mha_num_pkg::q_t i_x,          // x from the left
    input  mha_num_pkg::q_t i_w,          // weight from above
    input  mha_num_pkg::q_t i_d,          // partial sum from above
    input  logic            i_load_up,
    output mha_num_pkg::q_t o_x,          // x to the right
    output mha_num_pkg::q_t o_w,          // weight to the PE below
    output mha_num_pkg::q_t o_d,          // partial sum downward
    output logic            o_load_down
);

    import mha_num_pkg::*;

    q_t    w_q;        // stationary weight
    logic  load_q;     // load seen last cycle
    prod_t prod;
    q_t    prod_rnd;

    // Signed Q4.26 product of x and the held weight
    assign prod = i_x * w_q;

    // Sign, bits 27..13, plus bit 12 as round-up
    // Wraps at 16 bits like the accumulate
    assign prod_rnd = {prod[31], prod[`MHA_FRAC+14:`MHA_FRAC]}
                    + {15'd0, prod[`MHA_FRAC-1]};

    always_ff @(posedge I_CLK or negedge I_ASYN_RSTN) begin
        if (!I_ASYN_RSTN) begin
            o_x         <= '0;
            o_w         <= '0;
            o_d         <= '0;
            w_q         <= '0;
            load_q      <= 1'b0;
            o_load_down <= 1'b0;
        end else begin
            o_x    <= i_x;
            o_d    <= i_d + prod_rnd;
            load_q <= i_load_up;
            // Flag goes down one cycle shorter than it came in
            o_load_down <= i_load_up & load_q;
            if (i_load_up) begin
                // Keep the newest weight, pass the older one down
                w_q <= i_w;
                o_w <= w_q;
            end
        end
    end

endmodule

/* src/mha_skew_line.sv */
`timescale 1ns/100ps

module mha_skew_line #(
    parameter type T     = logic,
    parameter int  DEPTH = 1
) (
    input  logic I_CLK,
    input  logic I_ASYN_RSTN,
    input  T     i_d,
    output T     o_d
);

    generate
        if (DEPTH == 0) begin : g_wire
            // No delay asked for
            assign o_d = i_d;
        end else begin : g_regs
            T stage [DEPTH];

            always_ff @(posedge I_CLK or negedge I_ASYN_RSTN) begin
                if (!I_ASYN_RSTN) begin
                    for (int i = 0; i < DEPTH; i++) begin
                        stage[i] <= '0;
                    end
                end else begin
                    stage[0] <= i_d;
                    // Shift toward the output end
                    for (int i = 1; i < DEPTH; i++) begin
                        stage[i] <= stage[i-1];
                    end
                end
            end

            // Last stage is the output
            assign o_d = stage[DEPTH-1];
        end
    endgenerate

endmodule

/* src/mha_beat_pkg.sv */
package mha_beat_pkg;

    import mha_num_pkg::*;

    ///////////////////////////////////////////////////////////////////////
    // Beats on the top-level ports
    ///////////////////////////////////////////////////////////////////////

    // x row, split between the two arrays
    typedef struct packed {
        logic        valid;
        q_half_vec_t x_lo;   // x[0..3]
        q_half_vec_t x_hi;   // x[4..7]
    } x_beat_t;

    // One W row per array per load cycle
    typedef struct packed {
        logic   load;
        q_row_t row_lo;      // rows 3..0, last first
        q_row_t row_hi;      // rows 7..4, last first
    } w_beat_t;

    // Result row
    typedef struct packed {
        logic   valid;
        q_row_t y;
    } y_beat_t;

endpackage

/* src/mha_num_pkg.sv */
`include "mha_macros.svh"

package mha_num_pkg;

    // One Q2.13 value
    // sign, 2 int bits, 13 fraction bits
    typedef logic signed [15:0] q_t;

    // Full 16x16 signed product
    typedef logic signed [31:0] prod_t;

    // Half of an x row, or one column of weights
    typedef q_t [`MHA_K_HALF-1:0] q_half_vec_t;

    // One W row or one result row
    typedef q_t [`MHA_N-1:0] q_row_t;

endpackage

/* src/mha_macros.svh */
`ifndef MHA_MACROS_SVH
`define MHA_MACROS_SVH

// Shared sizes of the projection engine

// W rows held by one array, also PE rows per array
`define MHA_K_HALF 4

// Output columns, also PE columns per array
`define MHA_N 4

// Fraction bits of Q2.13
// Rounding bit sits one below
`define MHA_FRAC 13

// x row length over both arrays
`define MHA_K_FULL (2 * `MHA_K_HALF)

`endif
